// File: vlog.f
source/map_geom_pkg.sv
source/game_ctrl_pkg.sv
source/mode_control.sv
source/spawn_random.sv
source/obstacle_field.sv
source/score_counter.sv
source/obstacle_render.sv
source/obstacle_map.sv
tests/obstacle_map_tb.sv

// File: Bender.yml
package:
  name: obstacle_map

sources:
  - source/map_geom_pkg.sv
  - source/game_ctrl_pkg.sv
  - source/mode_control.sv
  - source/spawn_random.sv
  - source/obstacle_field.sv
  - source/score_counter.sv
  - source/obstacle_render.sv
  - source/obstacle_map.sv
  - target: test
    files:
      - tests/obstacle_map_tb.sv

// File: tests/obstacle_map_tb.sv
// Runs one fixed phase sequence at the default slot count and scroll step, with the score limit at 5
`timescale 1ns/1ps

module obstacle_map_tb;
    import game_ctrl_pkg::*;
    import map_geom_pkg::*;

    localparam int NUM_SLOTS   = 10;
    localparam int STEP        = 4;
    localparam int SCORE_LIMIT = 5;
    localparam int X_OFF       = 700;
    localparam int Y_OFF       = 500;

    // Check set bits
    localparam int CHK_IDLE    = 1;
    localparam int CHK_PAUSE   = 2;
    localparam int CHK_APPEAR  = 4;

    logic       clk;
    logic       rst_n;
    game_mode_e gamemode;
    score_t     score;
    x_coord_t   x_left     [NUM_SLOTS];
    x_coord_t   x_right    [NUM_SLOTS];
    y_coord_t   y_up       [NUM_SLOTS];
    y_coord_t   y_down     [NUM_SLOTS];

    // Outputs as sampled one cycle earlier
    x_coord_t   prev_left  [NUM_SLOTS];
    x_coord_t   prev_right [NUM_SLOTS];
    y_coord_t   prev_up    [NUM_SLOTS];
    y_coord_t   prev_down  [NUM_SLOTS];
    score_t     prev_score;

    // Modes driven one and two cycles back
    game_mode_e mode_d1;
    game_mode_e mode_d2;

    // Phase table
    game_mode_e ph_mode  [5];
    int         ph_len   [5];
    int         ph_chk   [5];
    int         ph_score [5];

    int         exits;
    int         exit_hist [64];
    int         cycle_cnt;
    int         run_streak;
    int         err_cnt;
    integer     seed;
    bit         appeared;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    obstacle_map #(
        .num_obstacles (NUM_SLOTS),
        .scroll_speed  (STEP),
        .score_max     (SCORE_LIMIT)
    ) i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .gamemode         (gamemode),
        .score            (score),
        .obstacle_x_left  (x_left),
        .obstacle_x_right (x_right),
        .obstacle_y_up    (y_up),
        .obstacle_y_down  (y_down)
    );

    // ====================
    // Reporting
    // ====================

    task automatic value_error(input string name, input int got, input int exp);
        err_cnt++;
        $display("error: %s = 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle_cnt);
    endtask

    task automatic range_error(input string name, input int got, input int lo, input int hi);
        err_cnt++;
        $display("error: %s = 0x%0h, expected 0x%0h to 0x%0h (cycle %0d)",
                 name, got, lo, hi, cycle_cnt);
    endtask

    task automatic note_failure(input string what);
        err_cnt++;
        $display("%s at cycle %0d", what, cycle_cnt);
    endtask

    task automatic load_phase(input int idx, input game_mode_e mode, input int len,
                              input int chk, input int end_score);
        ph_mode[idx]  = mode;
        ph_len[idx]   = len;
        ph_chk[idx]   = chk;
        ph_score[idx] = end_score;
    endtask

    // ====================
    // Checks
    // ====================

    // Slot edges, scrolling and exit counting for one sample
    task automatic check_slots(input int chk, input int cyc);
        bit vis;
        bit was_vis;
        int w;
        int h;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            vis     = (x_left[k] != X_OFF);
            was_vis = (prev_left[k] != X_OFF);
            w       = int'(x_right[k]) - int'(x_left[k]);
            h       = int'(y_down[k]) - int'(y_up[k]);
            if (!vis && (x_right[k] != X_OFF || y_up[k] != Y_OFF || y_down[k] != Y_OFF))
                note_failure($sformatf("slot %0d mixes sentinel and real edges", k));
            if (vis) begin
                appeared = appeared || ((chk & CHK_APPEAR) != 0);
                if (x_left[k] >= 640)
                    range_error($sformatf("obstacle_x_left[%0d]", k), x_left[k], 0, 639);
                if (w < 20 || w > 80)
                    range_error($sformatf("slot %0d width", k), w, 20, 80);
                if (h < 20 || h > 150)
                    range_error($sformatf("slot %0d height", k), h, 20, 150);
                if (y_up[k] < 20)
                    range_error($sformatf("obstacle_y_up[%0d]", k), y_up[k], 20, 460);
                if (y_down[k] > 460)
                    range_error($sformatf("obstacle_y_down[%0d]", k), y_down[k], 20, 460);
                // Slot state moved on the edge that saw the mode from two samples back
                if (mode_d2 == MODE_RUN && was_vis && x_left[k] != prev_left[k] - STEP)
                    value_error($sformatf("obstacle_x_left[%0d]", k), x_left[k],
                                prev_left[k] - STEP);
                if (mode_d2 == MODE_RUN && !was_vis && x_left[k] != 640 - STEP)
                    value_error($sformatf("obstacle_x_left[%0d]", k), x_left[k], 640 - STEP);
            end
            if (was_vis && !vis && mode_d2 == MODE_RUN)
                exits++;
            if ((chk & CHK_IDLE) != 0 && cyc >= 2 && vis)
                note_failure($sformatf("slot %0d still on screen in idle", k));
            if ((chk & CHK_PAUSE) != 0 && cyc >= 3 &&
                (x_left[k] != prev_left[k] || x_right[k] != prev_right[k] ||
                 y_up[k] != prev_up[k] || y_down[k] != prev_down[k]))
                note_failure($sformatf("slot %0d changed during pause", k));
        end
    endtask

    task automatic check_score(input int chk, input int cyc);
        int lower;
        exit_hist[cycle_cnt % 64] = exits;
        if (score > SCORE_LIMIT || score > exits)
            range_error("score", score, 0, (exits < SCORE_LIMIT) ? exits : SCORE_LIMIT);
        if (mode_d1 != MODE_IDLE && mode_d2 != MODE_IDLE && score < prev_score)
            range_error("score", score, prev_score, SCORE_LIMIT);
        // Any exit is scored within 47 cycles of steady running
        if (run_streak >= 60) begin
            lower = exit_hist[(cycle_cnt - 48) % 64];
            if (lower > SCORE_LIMIT)
                lower = SCORE_LIMIT;
            if (score < lower)
                range_error("score", score, lower, SCORE_LIMIT);
        end
        if ((chk & CHK_IDLE) != 0 && cyc >= 2 && score != 0)
            value_error("score", score, 0);
        if ((chk & CHK_PAUSE) != 0 && cyc >= 3 && score != prev_score)
            value_error("score", score, prev_score);
    endtask

    task automatic save_prev();
        for (int k = 0; k < NUM_SLOTS; k++) begin
            prev_left[k]  = x_left[k];
            prev_right[k] = x_right[k];
            prev_up[k]    = y_up[k];
            prev_down[k]  = y_down[k];
        end
        prev_score = score;
    endtask

    // ====================
    // Sequence
    // ====================

    initial begin
        seed       = 32'hd83fd642;
        err_cnt    = 0;
        cycle_cnt  = 0;
        run_streak = 0;
        exits      = 0;
        appeared   = 1'b0;
        rst_n      = 1'b0;
        gamemode   = MODE_IDLE;
        mode_d1    = MODE_IDLE;
        mode_d2    = MODE_IDLE;
        prev_score = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            prev_left[k]  = X_OFF;
            prev_right[k] = X_OFF;
            prev_up[k]    = Y_OFF;
            prev_down[k]  = Y_OFF;
        end

        // Mode, cycles, check set, score at phase end (-1 for none)
        load_phase(0, MODE_IDLE, 10, CHK_IDLE, 0);
        load_phase(1, MODE_RUN, 3000, 0, SCORE_LIMIT);
        load_phase(2, MODE_PAUSE, 20 + ($unsigned($random(seed)) % 40), CHK_PAUSE, SCORE_LIMIT);
        load_phase(3, MODE_IDLE, 10, CHK_IDLE, 0);
        load_phase(4, MODE_RUN, 200, CHK_APPEAR, -1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_slots(CHK_IDLE, 2);
        check_score(CHK_IDLE, 2);

        for (int p = 0; p < 5; p++) begin
            for (int c = 0; c < ph_len[p]; c++) begin
                @(negedge clk);
                cycle_cnt++;
                check_slots(ph_chk[p], c);
                check_score(ph_chk[p], c);
                save_prev();
                // Exit count restarts along with the score
                if (ph_mode[p] == MODE_IDLE && c == 0)
                    exits = 0;
                gamemode   = ph_mode[p];
                mode_d2    = mode_d1;
                mode_d1    = ph_mode[p];
                run_streak = (ph_mode[p] == MODE_RUN) ? run_streak + 1 : 0;
            end
            if (ph_score[p] >= 0 && score != ph_score[p])
                value_error("score", score, ph_score[p]);
            if ((ph_chk[p] & CHK_APPEAR) != 0 && !appeared)
                note_failure("no obstacle appeared after returning to run");
        end

        $display("cycles: %0d, exits: %0d, errors: %0d", cycle_cnt, exits, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: source/obstacle_map.sv
// Obstacle generator top; gamemode must be synchronous to clk and outputs lag slot state by one clock
`timescale 1ns/1ps

module obstacle_map #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4,
    parameter int score_max     = 9999
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  game_ctrl_pkg::game_mode_e gamemode,
    output game_ctrl_pkg::score_t     score,
    output map_geom_pkg::x_coord_t    obstacle_x_left  [num_obstacles],
    output map_geom_pkg::x_coord_t    obstacle_x_right [num_obstacles],
    output map_geom_pkg::y_coord_t    obstacle_y_up    [num_obstacles],
    output map_geom_pkg::y_coord_t    obstacle_y_down  [num_obstacles]
);
    import map_geom_pkg::*;

    logic                     run;
    logic                     clear;

    // Candidate obstacle for the next spawn
    obs_width_t               new_width;
    obs_height_t              new_height;
    y_coord_t                 new_y;
    gap_t                     new_gap;

    // Slot state
    logic [num_obstacles-1:0] slot_active;
    pos_x_t                   slot_x [num_obstacles];
    y_coord_t                 slot_y [num_obstacles];
    obs_width_t               slot_w [num_obstacles];
    obs_height_t              slot_h [num_obstacles];
    logic [3:0]               removed_count;

    // ====================
    // Input side
    // ====================

    mode_control i_mode_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .gamemode (gamemode),
        .run      (run),
        .clear    (clear)
    );

    spawn_random i_spawn_random (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_width  (new_width),
        .new_height (new_height),
        .new_y      (new_y),
        .new_gap    (new_gap)
    );

    // ====================
    // Processing
    // ====================

    obstacle_field #(
        .num_obstacles (num_obstacles),
        .scroll_speed  (scroll_speed)
    ) i_obstacle_field (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .clear         (clear),
        .new_width     (new_width),
        .new_height    (new_height),
        .new_y         (new_y),
        .new_gap       (new_gap),
        .active        (slot_active),
        .pos_x         (slot_x),
        .pos_y         (slot_y),
        .width         (slot_w),
        .height        (slot_h),
        .removed_count (removed_count)
    );

    score_counter #(
        .score_max (score_max)
    ) i_score_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .removed_count (removed_count),
        .score         (score)
    );

    // ====================
    // Output side
    // ====================

    obstacle_render #(
        .num_obstacles (num_obstacles)
    ) i_obstacle_render (
        .clk              (clk),
        .rst_n            (rst_n),
        .active           (slot_active),
        .pos_x            (slot_x),
        .pos_y            (slot_y),
        .width            (slot_w),
        .height           (slot_h),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

endmodule

// File: source/obstacle_render.sv
// Edges appear one clock after slot state; slots partly past the left edge already read as off-screen
`timescale 1ns/1ps

module obstacle_render #(
    parameter int num_obstacles = 10
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [num_obstacles-1:0]  active,
    input  map_geom_pkg::pos_x_t      pos_x  [num_obstacles],
    input  map_geom_pkg::y_coord_t    pos_y  [num_obstacles],
    input  map_geom_pkg::obs_width_t  width  [num_obstacles],
    input  map_geom_pkg::obs_height_t height [num_obstacles],
    output map_geom_pkg::x_coord_t    obstacle_x_left  [num_obstacles],
    output map_geom_pkg::x_coord_t    obstacle_x_right [num_obstacles],
    output map_geom_pkg::y_coord_t    obstacle_y_up    [num_obstacles],
    output map_geom_pkg::y_coord_t    obstacle_y_down  [num_obstacles]
);
    import map_geom_pkg::*;

    logic [num_obstacles-1:0] on_screen;

    // Left edge inside the visible columns
    always_comb begin
        for (int k = 0; k < num_obstacles; k++) begin
            on_screen[k] = active[k] && (pos_x[k] >= 0) && (pos_x[k] < SCREEN_WIDTH);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < num_obstacles; k++) begin
                obstacle_x_left[k]  <= X_OFFSCREEN;
                obstacle_x_right[k] <= X_OFFSCREEN;
                obstacle_y_up[k]    <= Y_OFFSCREEN;
                obstacle_y_down[k]  <= Y_OFFSCREEN;
            end
        end else begin
            for (int k = 0; k < num_obstacles; k++) begin
                if (on_screen[k]) begin
                    obstacle_x_left[k]  <= x_coord_t'(pos_x[k]);
                    obstacle_x_right[k] <= x_coord_t'(pos_x[k] + pos_x_t'(width[k]));
                    obstacle_y_up[k]    <= pos_y[k];
                    obstacle_y_down[k]  <= y_coord_t'(pos_y[k] + y_coord_t'(height[k]));
                end else begin
                    obstacle_x_left[k]  <= X_OFFSCREEN;
                    obstacle_x_right[k] <= X_OFFSCREEN;
                    obstacle_y_up[k]    <= Y_OFFSCREEN;
                    obstacle_y_down[k]  <= Y_OFFSCREEN;
                end
            end
        end
    end

endmodule

// File: source/score_counter.sv
// score_max must fit in 14 bits; the score only moves while removals are reported
`timescale 1ns/1ps

module score_counter #(
    parameter int score_max = 9999
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic [3:0]            removed_count,
    output game_ctrl_pkg::score_t score
);
    import game_ctrl_pkg::*;

    // One extra bit so the sum never wraps before the limit check
    logic [14:0] score_sum;

    assign score_sum = {1'b0, score} + 15'(removed_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else if (clear) begin
            score <= '0;
        end else if (score_sum > score_max) begin
            // Saturate
            score <= score_t'(score_max);
        end else begin
            score <= score_t'(score_sum);
        end
    end

endmodule

// File: source/obstacle_field.sv
// Up to 15 slots since removed_count is 4 bits; a due spawn waits while every slot is busy
`timescale 1ns/1ps

module obstacle_field #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      clear,
    input  map_geom_pkg::obs_width_t  new_width,
    input  map_geom_pkg::obs_height_t new_height,
    input  map_geom_pkg::y_coord_t    new_y,
    input  map_geom_pkg::gap_t        new_gap,
    output logic [num_obstacles-1:0]  active,
    output map_geom_pkg::pos_x_t      pos_x  [num_obstacles],
    output map_geom_pkg::y_coord_t    pos_y  [num_obstacles],
    output map_geom_pkg::obs_width_t  width  [num_obstacles],
    output map_geom_pkg::obs_height_t height [num_obstacles],
    output logic [3:0]                removed_count
);
    import map_geom_pkg::*;

    // Distance to the next spawn point, counts down while running
    pos_x_t                   spawn_dist;

    logic [num_obstacles-1:0] remove_hit;
    logic [3:0]               remove_sum;
    logic [num_obstacles-1:0] spawn_hit;
    logic [num_obstacles-1:0] spawn_load;
    logic                     slot_found;
    logic                     spawn_due;

    // ====================
    // Removal
    // ====================

    // Right edge past the delete line, all slots counted
    always_comb begin
        remove_hit = '0;
        remove_sum = '0;
        for (int i = 0; i < num_obstacles; i++) begin
            if (active[i] && (pos_x[i] + pos_x_t'(width[i]) < DELETE_BOUNDARY)) begin
                remove_hit[i] = 1'b1;
                remove_sum    = remove_sum + 4'd1;
            end
        end
    end

    // ====================
    // Spawn
    // ====================

    // Lowest free slot as seen at the start of the cycle
    always_comb begin
        spawn_hit  = '0;
        slot_found = 1'b0;
        for (int i = 0; i < num_obstacles; i++) begin
            if (!active[i] && !slot_found) begin
                spawn_hit[i] = 1'b1;
                slot_found   = 1'b1;
            end
        end
    end

    assign spawn_due  = (spawn_dist <= SCREEN_WIDTH);
    assign spawn_load = spawn_due ? spawn_hit : '0;

    // ====================
    // Slot control
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= '0;
            spawn_dist    <= pos_x_t'(SCREEN_WIDTH + MIN_GAP);
            removed_count <= '0;
        end else if (clear) begin
            active        <= '0;
            spawn_dist    <= pos_x_t'(SCREEN_WIDTH + MIN_GAP);
            removed_count <= '0;
        end else if (run) begin
            active        <= (active & ~remove_hit) | spawn_load;
            removed_count <= remove_sum;
            if (!spawn_due) begin
                spawn_dist <= spawn_dist - pos_x_t'(scroll_speed);
            end else if (slot_found) begin
                spawn_dist <= pos_x_t'(SCREEN_WIDTH) + pos_x_t'(new_gap);
            end
        end else begin
            // Paused, nothing leaves
            removed_count <= '0;
        end
    end

    // Slot payload, only meaningful while the slot is active
    always_ff @(posedge clk) begin
        if (run && !clear) begin
            for (int i = 0; i < num_obstacles; i++) begin
                if (spawn_load[i]) begin
                    pos_x[i]  <= pos_x_t'(SCREEN_WIDTH);
                    pos_y[i]  <= new_y;
                    width[i]  <= new_width;
                    height[i] <= new_height;
                end else if (active[i]) begin
                    pos_x[i] <= pos_x[i] - pos_x_t'(scroll_speed);
                end
            end
        end
    end

endmodule

// File: source/spawn_random.sv
// New obstacle parameters are valid every cycle; the sequence depends only on cycles since reset
`timescale 1ns/1ps

module spawn_random (
    input  logic                      clk,
    input  logic                      rst_n,
    output map_geom_pkg::obs_width_t  new_width,
    output map_geom_pkg::obs_height_t new_height,
    output map_geom_pkg::y_coord_t    new_y,
    output map_geom_pkg::gap_t        new_gap
);
    import map_geom_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h1234_5678;

    localparam int WIDTH_RANGE  = MAX_WIDTH - MIN_WIDTH + 1;
    localparam int HEIGHT_RANGE = MAX_HEIGHT - MIN_HEIGHT + 1;
    localparam int GAP_RANGE    = MAX_GAP - MIN_GAP + 1;

    logic [31:0] lfsr;
    logic        lfsr_fb;

    // Legal count of top rows for the chosen height
    logic [8:0]  y_span;

    // ====================
    // Random source
    // ====================

    // Taps 32, 22, 2, 1 give a maximal length sequence
    assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[30:0], lfsr_fb};
        end
    end

    // ====================
    // Derived values
    // ====================

    always_comb begin
        // Each dimension from its own byte
        new_width  = obs_width_t'(MIN_WIDTH + lfsr[7:0] % WIDTH_RANGE);
        new_height = obs_height_t'(MIN_HEIGHT + lfsr[15:8] % HEIGHT_RANGE);
        new_gap    = gap_t'(MIN_GAP + lfsr[23:16] % GAP_RANGE);

        // Bottom edge may touch LOWER_BOUND but not cross it
        y_span = 9'(LOWER_BOUND - UPPER_BOUND + 1 - int'(new_height));

        // Upper half word gives enough spread for the full range of rows
        new_y = y_coord_t'(UPPER_BOUND + lfsr[31:16] % y_span);
    end

endmodule

// File: source/mode_control.sv
// Run and clear are decoded combinationally from the mode input, so that input must be synchronous to clk
`timescale 1ns/1ps

module mode_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  game_ctrl_pkg::game_mode_e gamemode,
    output logic                      run,
    output logic                      clear
);
    import game_ctrl_pkg::*;

    game_mode_e mode_prev;

    // Previous mode, used to spot the idle to run transition
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_prev <= MODE_IDLE;
        end else begin
            mode_prev <= gamemode;
        end
    end

    always_comb begin
        run   = 1'b0;
        clear = 1'b0;
        case (gamemode)
            MODE_IDLE: begin
                clear = 1'b1;
            end
            MODE_RUN: begin
                run   = 1'b1;
                // Fresh game when coming straight out of idle
                clear = (mode_prev == MODE_IDLE);
            end
            MODE_PAUSE, MODE_HOLD: begin
                // Everything holds
                run   = 1'b0;
                clear = 1'b0;
            end
        endcase
    end

endmodule

// File: source/game_ctrl_pkg.sv
// Game control encodings; any mode other than idle and run freezes the game

package game_ctrl_pkg;

    // Game mode as driven by the host
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'b00,
        MODE_RUN   = 2'b01,
        MODE_PAUSE = 2'b10,
        MODE_HOLD  = 2'b11
    } game_mode_e;

    // Wide enough for a four digit score
    typedef logic [13:0] score_t;

endpackage

// File: source/map_geom_pkg.sv
// Playfield constants assume a 640 pixel wide screen and obstacles kept between rows 20 and 460

package map_geom_pkg;

    // ====================
    // Coordinate types
    // ====================

    // Internal x positions go negative while obstacles leave on the left
    typedef logic signed [11:0] pos_x_t;

    // Coordinates as seen by the display side
    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;

    // Obstacle dimensions and spacing
    typedef logic [6:0] obs_width_t;
    typedef logic [7:0] obs_height_t;
    typedef logic [7:0] gap_t;

    // ====================
    // Screen geometry
    // ====================

    localparam int SCREEN_WIDTH    = 640;
    localparam int UPPER_BOUND     = 20;
    localparam int LOWER_BOUND     = 460;

    // Well past the left edge so the widest obstacle is gone before its slot frees
    localparam int DELETE_BOUNDARY = -100;

    // ====================
    // Obstacle size limits
    // ====================

    localparam int MIN_WIDTH  = 20;
    localparam int MAX_WIDTH  = 80;
    localparam int MIN_HEIGHT = 20;
    localparam int MAX_HEIGHT = 150;
    localparam int MIN_GAP    = 80;
    localparam int MAX_GAP    = 180;

    // Off-screen markers for unused slots
    localparam x_coord_t X_OFFSCREEN = 10'd700;
    localparam y_coord_t Y_OFFSCREEN = 9'd500;

endpackage
